// ==== design/fifo_pkg.sv ====
package fifo_pkg;

   // --------------------
   // Default sizes
   // --------------------
   parameter int DEFAULT_DEPTH      = 16;  // FIFO entries
   parameter int DEFAULT_AFULL_VAL  = 12;  // Almost-full at or above this count
   parameter int DEFAULT_AEMPTY_VAL = 4;   // Almost-empty at or below this count

   // --------------------
   // Shared struct types
   // --------------------

   // Level flags, registered in the occupancy tracker
   typedef struct packed {
      logic full;    // Occupancy equals depth
      logic afull;   // Occupancy at or above threshold
      logic empty;   // Nothing stored
      logic aempty;  // Occupancy at or below threshold
   } fifo_flags_t;

   // Error pulses, one cycle wide
   typedef struct packed {
      logic overflow;   // Write request while full
      logic underflow;  // Read request while empty
   } fifo_err_t;

   // Completion pulses, one cycle after the accepted strobe
   typedef struct packed {
      logic wack;  // Write acknowledge
      logic dvld;  // Read data valid
   } fifo_ack_t;

endpackage

// ==== design/fifo_write_port.sv ====
`timescale 1ns/1ps

module fifo_write_port #(
   parameter int  DEPTH = fifo_pkg::DEFAULT_DEPTH,
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1  // Address width
) (
   input  logic          pos_clk,
   input  logic          aresetn,
   input  logic          we_i,         // Write request strobe
   input  logic          full_i,       // Registered full flag
   output logic          wr_accept_o,  // Accepted write, same cycle
   output logic [AW-1:0] waddr_o,      // Memory write address
   output logic          wack_o,       // Acknowledge pulse
   output logic          overflow_o    // Dropped write pulse
);

   // Last valid address before wrap
   localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

   // --------------------
   // Write gating
   // --------------------

   // Request passes only while not full
   assign wr_accept_o = we_i & ~full_i;

   // --------------------
   // Write address
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_o <= '0;
      end else if (wr_accept_o) begin
         if (waddr_o == LAST_ADDR) begin
            waddr_o <= '0;                // Wrap at depth
         end else begin
            waddr_o <= waddr_o + 1'b1;    // Next entry
         end
      end
   end

   // --------------------
   // Handshake pulses
   // --------------------

   // Both pulses last exactly one cycle after the request
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o     <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         wack_o     <= wr_accept_o;       // Write taken
         overflow_o <= we_i & full_i;     // Write dropped
      end
   end

endmodule

// ==== design/fifo_read_port.sv ====
`timescale 1ns/1ps

module fifo_read_port #(
   parameter int  DEPTH = fifo_pkg::DEFAULT_DEPTH,
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1  // Address width
) (
   input  logic          pos_clk,
   input  logic          aresetn,
   input  logic          re_i,         // Read request strobe
   input  logic          empty_i,      // Registered empty flag
   output logic          rd_accept_o,  // Accepted read, same cycle
   output logic [AW-1:0] raddr_o,      // Memory read address
   output logic          dvld_o,       // Data valid pulse
   output logic          underflow_o   // Dropped read pulse
);

   // Last valid address before wrap
   localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

   // --------------------
   // Read gating
   // --------------------

   // Request passes only while something is stored
   assign rd_accept_o = re_i & ~empty_i;

   // --------------------
   // Read address
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         raddr_o <= '0;
      end else if (rd_accept_o) begin
         if (raddr_o == LAST_ADDR) begin
            raddr_o <= '0;                // Wrap at depth
         end else begin
            raddr_o <= raddr_o + 1'b1;    // Next entry
         end
      end
   end

   // --------------------
   // Handshake pulses
   // --------------------

   // Memory data is ready the cycle after the read strobe
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_o      <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         dvld_o      <= rd_accept_o;      // Read taken
         underflow_o <= re_i & empty_i;   // Read dropped
      end
   end

endmodule

// ==== design/fifo_occupancy.sv ====
`timescale 1ns/1ps

module fifo_occupancy #(
   parameter int  DEPTH      = fifo_pkg::DEFAULT_DEPTH,
   parameter int  AFULL_VAL  = fifo_pkg::DEFAULT_AFULL_VAL,
   parameter int  AEMPTY_VAL = fifo_pkg::DEFAULT_AEMPTY_VAL,
   localparam int CW         = $clog2(DEPTH + 1)  // Holds 0 through DEPTH
) (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  wr_accept_i,  // Write taken this cycle
   input  logic                  rd_accept_i,  // Read taken this cycle
   output fifo_pkg::fifo_flags_t flags_o,      // Registered level flags
   output logic [CW-1:0]         count_o       // Occupancy, one cycle late
);

   // Thresholds sized to the counter
   localparam logic [CW-1:0] FULL_CNT   = CW'(DEPTH);
   localparam logic [CW-1:0] AFULL_CNT  = CW'(AFULL_VAL);
   localparam logic [CW-1:0] AEMPTY_CNT = CW'(AEMPTY_VAL);

   logic [CW-1:0]         occ_q;      // Current occupancy
   logic [CW-1:0]         occ_nxt;    // Occupancy after a one-way transfer
   logic                  one_way;    // Exactly one strobe accepted
   fifo_pkg::fifo_flags_t flags_nxt;  // Flag values for occ_nxt

   // --------------------
   // Transfer direction
   // --------------------

   // A write plus a read in the same cycle cancel out
   assign one_way = wr_accept_i ^ rd_accept_i;

   // Only meaningful while one_way is high
   always_comb begin
      if (wr_accept_i) begin
         occ_nxt = occ_q + CW'(1);   // One more entry
      end else begin
         occ_nxt = occ_q - CW'(1);   // One less entry
      end
   end

   // --------------------
   // Occupancy counter
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         occ_q <= '0;
      end else if (one_way) begin
         occ_q <= occ_nxt;
      end
   end

   // --------------------
   // Next flag values
   // --------------------

   // Flags describe the state after this transfer,
   // so they are compared against occ_nxt and not occ_q
   always_comb begin
      flags_nxt        = '0;
      flags_nxt.full   = (occ_nxt == FULL_CNT);    // Last slot just filled
      flags_nxt.afull  = (occ_nxt >= AFULL_CNT);   // Upper threshold
      flags_nxt.empty  = (occ_nxt == '0);          // Last entry just left
      flags_nxt.aempty = (occ_nxt <= AEMPTY_CNT);  // Lower threshold
   end

   // --------------------
   // Flag registers
   // --------------------

   // Held through idle cycles and balanced transfers
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         flags_o.full   <= 1'b0;
         flags_o.afull  <= 1'b0;
         flags_o.empty  <= 1'b1;   // Starts with nothing stored
         flags_o.aempty <= 1'b1;
      end else if (one_way) begin
         flags_o <= flags_nxt;
      end
   end

   // --------------------
   // Count output
   // --------------------

   // Registered copy, lags the flags by one more cycle
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_o <= '0;
      end else begin
         count_o <= occ_q;
      end
   end

endmodule

// ==== design/sync_fifo_ctrl.sv ====
`timescale 1ns/1ps

module sync_fifo_ctrl #(
   parameter int  DEPTH      = fifo_pkg::DEFAULT_DEPTH,
   parameter int  AFULL_VAL  = fifo_pkg::DEFAULT_AFULL_VAL,
   parameter int  AEMPTY_VAL = fifo_pkg::DEFAULT_AEMPTY_VAL,
   localparam int AW         = (DEPTH > 1) ? $clog2(DEPTH) : 1,  // Address width
   localparam int CW         = $clog2(DEPTH + 1)                 // Count width
) (
   input  logic                  pos_clk,
   input  logic                  aresetn,
   input  logic                  we_i,        // Write request
   input  logic                  re_i,        // Read request
   output fifo_pkg::fifo_flags_t flags_o,     // full, afull, empty, aempty
   output logic [CW-1:0]         count_o,     // Occupancy count
   output fifo_pkg::fifo_err_t   err_o,       // overflow, underflow
   output fifo_pkg::fifo_ack_t   ack_o,       // wack, dvld
   output logic                  memwe_o,     // Memory write enable
   output logic [AW-1:0]         memwaddr_o,  // Memory write address
   output logic                  memre_o,     // Memory read enable
   output logic [AW-1:0]         memraddr_o   // Memory read address
);

   logic wr_accept;  // Write gated by full
   logic rd_accept;  // Read gated by empty

   // --------------------
   // Write port
   // --------------------
   fifo_write_port #(
      .DEPTH (DEPTH)
   ) u_write_port (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .full_i      (flags_o.full),     // Feedback from tracker
      .wr_accept_o (wr_accept),
      .waddr_o     (memwaddr_o),
      .wack_o      (ack_o.wack),
      .overflow_o  (err_o.overflow)
   );

   // --------------------
   // Read port
   // --------------------
   fifo_read_port #(
      .DEPTH (DEPTH)
   ) u_read_port (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .empty_i     (flags_o.empty),    // Feedback from tracker
      .rd_accept_o (rd_accept),
      .raddr_o     (memraddr_o),
      .dvld_o      (ack_o.dvld),
      .underflow_o (err_o.underflow)
   );

   // --------------------
   // Occupancy tracker
   // --------------------
   fifo_occupancy #(
      .DEPTH      (DEPTH),
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) u_occupancy (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .flags_o     (flags_o),
      .count_o     (count_o)
   );

   // Memory strobes are the accepted requests, same cycle
   assign memwe_o = wr_accept;
   assign memre_o = rd_accept;

endmodule

// ==== include/fifo_tb_checks.svh ====
`ifndef FIFO_TB_CHECKS_SVH
`define FIFO_TB_CHECKS_SVH

// --------------------
// Error counters
// --------------------
int flag_err_cnt  = 0;  // Level flag mismatches
int pulse_err_cnt = 0;  // Error and completion pulse mismatches
int value_err_cnt = 0;  // Count and address mismatches

// --------------------
// Compare tasks
// --------------------

// Level flags as one 4-bit word, full first
task automatic check_flags(input string                 test_name,
                           input fifo_pkg::fifo_flags_t exp,
                           input fifo_pkg::fifo_flags_t act);
   if (act !== exp) begin
      flag_err_cnt++;
      $display("Fail %s flags expected %b actual %b (full afull empty aempty)",
               test_name, exp, act);
   end
endtask

// overflow and underflow
task automatic check_err(input string               test_name,
                         input fifo_pkg::fifo_err_t exp,
                         input fifo_pkg::fifo_err_t act);
   if (act !== exp) begin
      pulse_err_cnt++;
      $display("Fail %s err expected ovf=%0b udf=%0b actual ovf=%0b udf=%0b",
               test_name, exp.overflow, exp.underflow, act.overflow, act.underflow);
   end
endtask

// wack and dvld
task automatic check_ack(input string               test_name,
                         input fifo_pkg::fifo_ack_t exp,
                         input fifo_pkg::fifo_ack_t act);
   if (act !== exp) begin
      pulse_err_cnt++;
      $display("Fail %s ack expected wack=%0b dvld=%0b actual wack=%0b dvld=%0b",
               test_name, exp.wack, exp.dvld, act.wack, act.dvld);
   end
endtask

// Count, addresses and single strobes
task automatic check_value(input string       test_name,
                           input int unsigned exp,
                           input int unsigned act);
   if (act !== exp) begin
      value_err_cnt++;
      $display("Fail %s expected %0d actual %0d", test_name, exp, act);
   end
endtask

`endif

// ==== dv/sync_fifo_ctrl_tb.sv ====
`timescale 1ns/1ps

module sync_fifo_ctrl_tb;

   localparam int DEPTH        = 16;
   localparam int AFULL_VAL    = 12;
   localparam int AEMPTY_VAL   = 4;
   localparam int CLK_PERIOD   = 8;    // ns
   localparam int RESET_CYCLES = 8;
   localparam int MIXED_CYCLES = 300;

   // One step per cycle: reset, fill, overflow, drain, underflow, mixed
   localparam int TEST_CYCLES = RESET_CYCLES + 1 + (DEPTH + 2) + 2 + (DEPTH + 1) + 2 +
                                MIXED_CYCLES + 2;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + 50;  // Plus a margin

   logic                  pos_clk;
   logic                  aresetn;
   logic                  we_i;
   logic                  re_i;
   fifo_pkg::fifo_flags_t flags_o;
   logic [4:0]            count_o;
   fifo_pkg::fifo_err_t   err_o;
   fifo_pkg::fifo_ack_t   ack_o;
   logic                  memwe_o;
   logic [3:0]            memwaddr_o;
   logic                  memre_o;
   logic [3:0]            memraddr_o;

   // --------------------
   // Reference model state
   // --------------------
   fifo_pkg::fifo_flags_t m_flags;       // Registered flags
   fifo_pkg::fifo_err_t   m_err;         // Pulses due this cycle
   fifo_pkg::fifo_ack_t   m_ack;
   int                    m_occ;         // Occupancy after last edge
   int                    m_count;       // count_o, one cycle behind m_occ
   int                    m_waddr;
   int                    m_raddr;
   int                    both_cnt;      // Cycles with read and write accepted
   int                    wrap_cnt;      // Write address wraps
   logic [31:0]           lfsr_state = 32'hab98_a4f2;

   `include "fifo_tb_checks.svh"

   sync_fifo_ctrl #(
      .DEPTH      (DEPTH),
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) UUT (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we_i),
      .re_i       (re_i),
      .flags_o    (flags_o),
      .count_o    (count_o),
      .err_o      (err_o),
      .ack_o      (ack_o),
      .memwe_o    (memwe_o),
      .memwaddr_o (memwaddr_o),
      .memre_o    (memre_o),
      .memraddr_o (memraddr_o)
   );

   initial begin
      pos_clk = 1'b0;
      forever #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
   end

   // --------------------
   // Helpers
   // --------------------

   // Galois form, taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic take_bit(output logic b);
      b          = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);  // One step per bit
   endtask

   // Level flags for a given occupancy
   function automatic fifo_pkg::fifo_flags_t flags_for(input int occ);
      fifo_pkg::fifo_flags_t f;
      f.full   = (occ == DEPTH);
      f.afull  = (occ >= AFULL_VAL);
      f.empty  = (occ == 0);
      f.aempty = (occ <= AEMPTY_VAL);
      return f;
   endfunction

   task automatic reset_model();
      m_flags  = flags_for(0);
      m_err    = '0;
      m_ack    = '0;
      m_occ    = 0;
      m_count  = 0;
      m_waddr  = 0;
      m_raddr  = 0;
      both_cnt = 0;
      wrap_cnt = 0;
   endtask

   // Advance the model across the edge that ends this cycle
   task automatic model_update(input logic we, input logic re);
      logic wa;
      logic ra;
      wa              = we & ~m_flags.full;    // Gated by current flags
      ra              = re & ~m_flags.empty;
      m_ack.wack      = wa;
      m_ack.dvld      = ra;
      m_err.overflow  = we & m_flags.full;
      m_err.underflow = re & m_flags.empty;
      m_count         = m_occ;                 // Registered copy
      if (wa) begin
         m_waddr = (m_waddr + 1) % DEPTH;
         if (m_waddr == 0) wrap_cnt++;
      end
      if (ra) m_raddr = (m_raddr + 1) % DEPTH;
      if (wa && !ra) begin
         m_occ++;
         m_flags = flags_for(m_occ);
      end else if (ra && !wa) begin
         m_occ--;
         m_flags = flags_for(m_occ);
      end else if (wa && ra) begin
         both_cnt++;                           // Flags and occupancy hold
      end
   endtask

   // Drive one cycle, compare at the falling edge, then step the model
   task automatic step(input logic we, input logic re, input string name);
      @(posedge pos_clk);
      we_i <= we;
      re_i <= re;
      @(negedge pos_clk);
      check_flags(name, m_flags, flags_o);
      check_err(name, m_err, err_o);
      check_ack(name, m_ack, ack_o);
      check_value({name, " count"}, m_count, 32'(count_o));
      check_value({name, " waddr"}, m_waddr, 32'(memwaddr_o));
      check_value({name, " raddr"}, m_raddr, 32'(memraddr_o));
      check_value({name, " memwe"}, 32'(we & ~m_flags.full), 32'(memwe_o));
      check_value({name, " memre"}, 32'(re & ~m_flags.empty), 32'(memre_o));
      model_update(we, re);
   endtask

   // --------------------
   // Directed tests
   // --------------------
   task automatic test_reset();
      step(1'b0, 1'b0, "reset");
      check_flags("reset", flags_for(0), flags_o);  // empty and aempty only
      check_err("reset", '0, err_o);
      check_ack("reset", '0, ack_o);
      check_value("reset count", 0, 32'(count_o));
      check_value("reset waddr", 0, 32'(memwaddr_o));
      check_value("reset raddr", 0, 32'(memraddr_o));
      check_value("reset memwe", 0, 32'(memwe_o));
      check_value("reset memre", 0, 32'(memre_o));
   endtask

   task automatic test_fill();
      for (int i = 0; i <= DEPTH; i++) begin
         step(i < DEPTH, 1'b0, "fill");
         check_flags("fill", flags_for(i), flags_o);       // After i writes
         check_value("fill wack", (i > 0) ? 1 : 0, 32'(ack_o.wack));
         if (i < DEPTH) begin
            check_value("fill waddr", i, 32'(memwaddr_o));
            check_value("fill memwe", 1, 32'(memwe_o));
         end
      end
      step(1'b0, 1'b0, "fill");
      check_value("fill count", DEPTH, 32'(count_o));     // Two cycles late
   endtask

   task automatic test_overflow();
      fifo_pkg::fifo_err_t exp_err;
      exp_err.overflow  = 1'b1;
      exp_err.underflow = 1'b0;
      step(1'b1, 1'b0, "overflow");
      check_value("overflow memwe", 0, 32'(memwe_o));   // Dropped
      step(1'b0, 1'b0, "overflow");
      check_err("overflow", exp_err, err_o);
      check_value("overflow waddr", 0, 32'(memwaddr_o));  // Still wrapped at 0
      check_value("overflow count", DEPTH, 32'(count_o));
   endtask

   task automatic test_drain();
      fifo_pkg::fifo_err_t exp_err;
      exp_err.overflow  = 1'b0;
      exp_err.underflow = 1'b1;
      for (int i = 0; i <= DEPTH; i++) begin
         step(1'b0, i < DEPTH, "drain");
         check_flags("drain", flags_for(DEPTH - i), flags_o);
         check_value("drain dvld", (i > 0) ? 1 : 0, 32'(ack_o.dvld));
         if (i < DEPTH) begin
            check_value("drain raddr", i, 32'(memraddr_o));
            check_value("drain memre", 1, 32'(memre_o));
         end
      end
      step(1'b0, 1'b1, "underflow");
      check_value("underflow memre", 0, 32'(memre_o));
      step(1'b0, 1'b0, "underflow");
      check_err("underflow", exp_err, err_o);
   endtask

   task automatic test_mixed();
      logic we;
      logic re;
      both_cnt = 0;
      wrap_cnt = 0;
      for (int n = 0; n < MIXED_CYCLES; n++) begin
         take_bit(we);
         take_bit(re);
         step(we, re, "mixed");
      end
      step(1'b0, 1'b0, "mixed");  // Let the last pulses and count settle
      step(1'b0, 1'b0, "mixed");
      if (both_cnt == 0) begin
         value_err_cnt++;
         $display("Mixed traffic never had a read and a write accepted together");
      end
      if (wrap_cnt < 2) begin
         value_err_cnt++;
         $display("Mixed traffic wrapped the write address only %0d times", wrap_cnt);
      end
   endtask

   // --------------------
   // Run
   // --------------------
   initial begin
      we_i    = 1'b0;
      re_i    = 1'b0;
      aresetn = 1'b0;
      reset_model();
      repeat (RESET_CYCLES) @(posedge pos_clk);
      aresetn <= 1'b1;
      test_reset();
      test_fill();
      test_overflow();
      test_drain();
      test_mixed();
      $display("Errors: flags %0d, pulses %0d, values %0d",
               flag_err_cnt, pulse_err_cnt, value_err_cnt);
      if (flag_err_cnt + pulse_err_cnt + value_err_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
design/fifo_pkg.sv
design/fifo_write_port.sv
design/fifo_read_port.sv
design/fifo_occupancy.sv
design/sync_fifo_ctrl.sv
dv/sync_fifo_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and grade the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing -Wno-fatal \
   -f list.f \
   --top-module sync_fifo_ctrl_tb \
   -Mdir "$BUILD_DIR" -o sim

"./$BUILD_DIR/sim" | tee "$LOG_FILE"

if grep -qx "TEST PASSED" "$LOG_FILE"; then
   echo "run.sh: simulation passed"
else
   echo "run.sh: simulation failed, see $LOG_FILE"
   exit 1
fi
